//--- common/dcache_settings.svh
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// Number of cache sets
`define DCACHE_SETS 32

// Words per line as a power of two (four words)
`define DCACHE_LINE_POW2 2

// Wishbone word address width, 4K words of SRAM
`define DCACHE_AW 12

// Byte-masked SRAM writes take a read-modify-write cycle when set
`define DCACHE_PARTIAL_WR_STALL 1

`endif

//--- common/dcache_pkg.sv
`default_nettype none

`include "dcache_settings.svh"

package dcache_pkg;

    // funct3 of RV32 loads and stores
    typedef enum logic [2:0] {
        MEM_BYTE   = 3'b000,
        MEM_HALF   = 3'b001,
        MEM_WORD   = 3'b010,
        MEM_BYTE_U = 3'b100,
        MEM_HALF_U = 3'b101
    } mem_size_e;

    localparam int SET_W = $clog2(`DCACHE_SETS);
    localparam int TAG_W = `DCACHE_AW - SET_W - `DCACHE_LINE_POW2;

    // Lookup view of a CPU byte address
    typedef struct packed {
        logic [TAG_W-1:0]             tag;
        logic [SET_W-1:0]             set_idx;
        logic [`DCACHE_LINE_POW2-1:0] word_idx;
        logic [1:0]                   byte_off;
    } cpu_addr_fields_t;

    // Same word seen as a flat byte address or as lookup fields
    typedef union packed {
        logic [`DCACHE_AW+1:0] flat;
        cpu_addr_fields_t      field;
    } cpu_addr_u;

endpackage

`default_nettype wire

//--- dcache/load_format.sv
`timescale 1ns/100ps
`default_nettype none

module load_format (
    input  wire logic [31:0]           ram_data_i,  // Word read from the cache
    input  wire logic [1:0]            byte_off_i,
    input  wire dcache_pkg::mem_size_e mem_ctrl_i,  // funct3
    output logic [31:0]                load_data_o  // Ready for the register file
);
    import dcache_pkg::*;

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    always_comb begin
        byte_sel = ram_data_i[8*byte_off_i +: 8];
        half_sel = byte_off_i[1] ? ram_data_i[31:16] : ram_data_i[15:0];  // Aligned halves only
    end

    always_comb begin
        case (mem_ctrl_i)
            MEM_BYTE: begin
                load_data_o = {{24{byte_sel[7]}}, byte_sel};
            end
            MEM_HALF: begin
                load_data_o = {{16{half_sel[15]}}, half_sel};
            end
            MEM_BYTE_U: begin
                load_data_o = {24'b0, byte_sel};
            end
            MEM_HALF_U: begin
                load_data_o = {16'b0, half_sel};
            end
            default: begin
                load_data_o = ram_data_i;  // Word
            end
        endcase
    end

endmodule

`default_nettype wire

//--- dcache/store_format.sv
`timescale 1ns/100ps
`default_nettype none

module store_format (
    input  wire logic [31:0]           store_data_i,  // Register value
    input  wire logic [1:0]            byte_off_i,
    input  wire dcache_pkg::mem_size_e mem_ctrl_i,    // funct3
    output logic [31:0]                store_data_o,  // Data placed in its lanes
    output logic [3:0]                 byte_en_o      // Cache RAM write and wb_sel
);
    import dcache_pkg::*;

    always_comb begin
        case (mem_ctrl_i)
            MEM_BYTE, MEM_BYTE_U: begin
                store_data_o = {4{store_data_i[7:0]}};  // Replicate into every lane
                byte_en_o    = 4'b0001 << byte_off_i;
            end
            MEM_HALF, MEM_HALF_U: begin
                store_data_o = {2{store_data_i[15:0]}};
                byte_en_o    = byte_off_i[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                store_data_o = store_data_i;
                byte_en_o    = 4'b1111;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- dcache/direct_mapped_cache_wb.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_settings.svh"

module direct_mapped_cache_wb (
    input  wire logic                   cpu_clock_i,
    input  wire logic                   rst_n_i,
    // CPU port
    input  wire dcache_pkg::cpu_addr_u  cpu_addr_i,      // Byte address
    input  wire logic [31:0]            cpu_data_i,      // Store data
    input  wire dcache_pkg::mem_size_e  cpu_mem_ctrl_i,  // funct3
    input  wire logic                   cpu_write_i,
    input  wire logic                   cpu_valid_i,
    output logic [31:0]                 cpu_data_o,      // Formatted load data
    output logic                        cpu_en_o,        // Low stalls the pipeline
    // Wishbone master
    input  wire logic                   wb_stall_i,
    input  wire logic                   wb_ack_i,
    input  wire logic                   wb_err_i,
    input  wire logic [31:0]            wb_dat_i,
    output logic                        wb_cyc_o,
    output logic                        wb_stb_o,
    output logic                        wb_we_o,
    output logic [`DCACHE_AW-1:0]       wb_adr_o,
    output logic [31:0]                 wb_dat_o,
    output logic [3:0]                  wb_sel_o
);
    import dcache_pkg::*;

    localparam int SETS   = `DCACHE_SETS;
    localparam int LP     = `DCACHE_LINE_POW2;
    localparam int AW     = `DCACHE_AW;
    localparam int RAM_SZ = SETS * (2**LP);
    localparam int RAM_AW = $clog2(RAM_SZ);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITE,   // Store miss goes straight to memory
        ST_EVICT,
        ST_FILL
    } cache_state_e;

    // Write-back, no-allocate storage
    logic [31:0]      cache_ram [0:RAM_SZ-1];
    logic [TAG_W-1:0] tags [0:SETS-1];
    logic [SETS-1:0]  valid;
    logic [SETS-1:0]  dirty;

    cache_state_e     state;

    logic [SET_W-1:0]  cpu_set;
    logic [TAG_W-1:0]  cpu_tag;
    logic [LP-1:0]     cpu_word;
    logic [TAG_W-1:0]  tag_read;
    logic              valid_read;
    logic              dirty_read;
    logic              cpu_hit;
    logic [31:0]       ram_data;
    logic [31:0]       evict_word;
    logic [31:0]       st_data;
    logic [3:0]        st_byte_en;
    logic              store_hit;
    logic              idle_store_miss;
    logic              idle_evict;
    logic              idle_fill;
    logic              beat_accept;
    logic              last_beat;
    logic              fill_beat;
    logic              fill_done;
    logic              evict_done;
    logic [LP-1:0]     fill_cnt;
    logic [LP-1:0]     evict_rq_cnt;
    logic [LP-1:0]     evict_ack_cnt;
    logic [3:0]        ram_wr_en;
    logic [RAM_AW-1:0] ram_wr_addr;
    logic [31:0]       ram_wr_data;

    assign cpu_set  = cpu_addr_i.field.set_idx;
    assign cpu_tag  = cpu_addr_i.field.tag;
    assign cpu_word = cpu_addr_i.field.word_idx;

    assign tag_read   = tags[cpu_set];
    assign valid_read = valid[cpu_set];
    assign dirty_read = dirty[cpu_set];
    assign cpu_hit    = valid_read && (tag_read == cpu_tag);

    assign ram_data   = cache_ram[{cpu_set, cpu_word}];
    assign evict_word = cache_ram[{cpu_set, evict_rq_cnt}];  // Word 0 while idle

    load_format lf0 (
        .ram_data_i  (ram_data),
        .byte_off_i  (cpu_addr_i.field.byte_off),
        .mem_ctrl_i  (cpu_mem_ctrl_i),
        .load_data_o (cpu_data_o)
    );

    store_format sf0 (
        .store_data_i (cpu_data_i),
        .byte_off_i   (cpu_addr_i.field.byte_off),
        .mem_ctrl_i   (cpu_mem_ctrl_i),
        .store_data_o (st_data),
        .byte_en_o    (st_byte_en)
    );

    // Decisions taken in the request cycle
    assign store_hit       = (state == ST_IDLE) && cpu_valid_i && cpu_write_i && cpu_hit;
    assign idle_store_miss = (state == ST_IDLE) && cpu_valid_i && cpu_write_i && !cpu_hit;
    assign idle_evict      = (state == ST_IDLE) && cpu_valid_i && !cpu_write_i && !cpu_hit
                             && valid_read && dirty_read;
    assign idle_fill       = (state == ST_IDLE) && cpu_valid_i && !cpu_write_i && !cpu_hit
                             && !(valid_read && dirty_read);

    assign beat_accept = wb_stb_o && !wb_stall_i;
    assign last_beat   = &wb_adr_o[LP-1:0];
    assign fill_beat   = (state == ST_FILL) && wb_ack_i;
    assign fill_done   = fill_beat && (&fill_cnt);
    assign evict_done  = (state == ST_EVICT) && wb_ack_i && (&evict_ack_cnt);

    // A store miss completes on its ack
    assign cpu_en_o = !(cpu_valid_i && !cpu_hit && !((state == ST_WRITE) && wb_ack_i));

    always_ff @(posedge cpu_clock_i) begin
        if (!rst_n_i) begin
            state         <= ST_IDLE;
            wb_cyc_o      <= 1'b0;
            wb_stb_o      <= 1'b0;
            wb_we_o       <= 1'b0;
            fill_cnt      <= '0;
            evict_rq_cnt  <= '0;
            evict_ack_cnt <= '0;
            valid         <= '0;
            dirty         <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (store_hit) begin
                        dirty[cpu_set] <= 1'b1;
                    end
                    if (idle_store_miss) begin
                        state    <= ST_WRITE;
                        wb_cyc_o <= 1'b1;
                        wb_stb_o <= 1'b1;
                        wb_we_o  <= 1'b1;
                    end else if (idle_evict) begin
                        state        <= ST_EVICT;
                        wb_cyc_o     <= 1'b1;
                        wb_stb_o     <= 1'b1;
                        wb_we_o      <= 1'b1;
                        evict_rq_cnt <= 1;  // Word 0 is already on the bus
                    end else if (idle_fill) begin
                        state    <= ST_FILL;
                        wb_cyc_o <= 1'b1;
                        wb_stb_o <= 1'b1;
                        wb_we_o  <= 1'b0;
                    end
                end
                ST_WRITE: begin
                    if (beat_accept) begin
                        wb_stb_o <= 1'b0;
                    end
                    if (wb_ack_i) begin
                        wb_cyc_o <= 1'b0;
                        state    <= ST_IDLE;
                    end
                end
                ST_EVICT: begin
                    if (beat_accept) begin
                        if (last_beat) begin
                            wb_stb_o <= 1'b0;
                        end else begin
                            evict_rq_cnt <= evict_rq_cnt + 1'b1;
                        end
                    end
                    if (wb_ack_i) begin
                        evict_ack_cnt <= evict_ack_cnt + 1'b1;
                    end
                    if (evict_done) begin
                        valid[cpu_set] <= 1'b0;
                        dirty[cpu_set] <= 1'b0;
                        state          <= ST_FILL;  // Cycle stays open into the fill
                        wb_stb_o       <= 1'b1;
                        wb_we_o        <= 1'b0;
                    end
                end
                ST_FILL: begin
                    if (beat_accept && last_beat) begin
                        wb_stb_o <= 1'b0;
                    end
                    if (fill_beat) begin
                        fill_cnt <= fill_cnt + 1'b1;
                    end
                    if (fill_done) begin
                        valid[cpu_set] <= 1'b1;
                        dirty[cpu_set] <= 1'b0;
                        wb_cyc_o       <= 1'b0;
                        state          <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Bus payload and tags
    always_ff @(posedge cpu_clock_i) begin
        if (idle_store_miss) begin
            wb_adr_o <= cpu_addr_i.flat[AW+1:2];
            wb_dat_o <= st_data;
            wb_sel_o <= st_byte_en;
        end else if (idle_evict) begin
            wb_adr_o <= {tag_read, cpu_set, {LP{1'b0}}};
            wb_dat_o <= evict_word;
            wb_sel_o <= 4'b1111;
        end else if (idle_fill || evict_done) begin
            wb_adr_o <= {cpu_tag, cpu_set, {LP{1'b0}}};
            wb_sel_o <= 4'b1111;
        end else if (beat_accept && !last_beat && (state != ST_WRITE)) begin
            wb_adr_o <= wb_adr_o + 1'b1;
            wb_dat_o <= evict_word;  // Next victim word, unused on reads
        end
        if (fill_done) begin
            tags[cpu_set] <= cpu_tag;
        end
    end

    // Fill beats take priority, they never coincide with a store hit
    assign ram_wr_en   = fill_beat ? 4'b1111 : (store_hit ? st_byte_en : 4'b0000);
    assign ram_wr_addr = fill_beat ? {cpu_set, fill_cnt} : {cpu_set, cpu_word};
    assign ram_wr_data = fill_beat ? wb_dat_i : st_data;

    always_ff @(posedge cpu_clock_i) begin
        for (int k = 0; k < 4; k++) begin
            if (ram_wr_en[k]) begin
                cache_ram[ram_wr_addr][8*k +: 8] <= ram_wr_data[8*k +: 8];
            end
        end
    end

    a_stb_in_cyc: assert property (@(posedge cpu_clock_i) disable iff (!rst_n_i)
        wb_stb_o |-> wb_cyc_o);

    // The SRAM must never signal an error on an open cycle
    a_no_bus_err: assert property (@(posedge cpu_clock_i) disable iff (!rst_n_i)
        wb_cyc_o |-> !wb_err_i);

    // Lookup must not report a hit while a line is in transit
    a_busy_stalls: assert property (@(posedge cpu_clock_i) disable iff (!rst_n_i)
        ((state != ST_IDLE) && cpu_valid_i && !((state == ST_WRITE) && wb_ack_i))
        |-> !cpu_en_o);

endmodule

`default_nettype wire

//--- hw/wb_sram.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_settings.svh"

module wb_sram (
    input  wire logic                  cpu_clock_i,
    input  wire logic                  rst_n_i,
    input  wire logic                  wb_cyc_i,
    input  wire logic                  wb_stb_i,
    input  wire logic                  wb_we_i,
    input  wire logic [`DCACHE_AW-1:0] wb_adr_i,  // Word address
    input  wire logic [31:0]           wb_dat_i,
    input  wire logic [3:0]            wb_sel_i,
    output logic                       wb_stall_o,
    output logic                       wb_ack_o,
    output logic [31:0]                wb_dat_o
);
    localparam int DEPTH  = 2**`DCACHE_AW;
    localparam bit RMW_EN = (`DCACHE_PARTIAL_WR_STALL != 0);

    logic [31:0]           mem [0:DEPTH-1];
    logic                  accept;
    logic                  rmw_start;
    logic                  rmw_pend;      // Merge writes back this cycle
    logic [`DCACHE_AW-1:0] rmw_adr;
    logic [31:0]           rmw_dat;
    logic [3:0]            rmw_sel;
    logic [31:0]           rmw_word;
    logic [31:0]           rmw_merged;

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    assign wb_stall_o = rmw_pend;
    assign accept     = wb_cyc_i && wb_stb_i && !wb_stall_o;
    assign rmw_start  = RMW_EN && accept && wb_we_i && (wb_sel_i != 4'b1111);

    always_comb begin
        for (int k = 0; k < 4; k++) begin
            rmw_merged[8*k +: 8] = rmw_sel[k] ? rmw_dat[8*k +: 8] : rmw_word[8*k +: 8];
        end
    end

    always @(posedge cpu_clock_i) begin
        if (rmw_pend) begin
            mem[rmw_adr] <= rmw_merged;
        end else if (accept && wb_we_i && !rmw_start) begin
            for (int k = 0; k < 4; k++) begin
                if (wb_sel_i[k]) begin
                    mem[wb_adr_i][8*k +: 8] <= wb_dat_i[8*k +: 8];
                end
            end
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        if (accept && !wb_we_i) begin
            wb_dat_o <= mem[wb_adr_i];  // Registered read
        end
        if (rmw_start) begin
            rmw_adr  <= wb_adr_i;
            rmw_dat  <= wb_dat_i;
            rmw_sel  <= wb_sel_i;
            rmw_word <= mem[wb_adr_i];
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        if (!rst_n_i) begin
            rmw_pend <= 1'b0;
            wb_ack_o <= 1'b0;
        end else begin
            rmw_pend <= rmw_start;
            wb_ack_o <= (accept && !rmw_start) || rmw_pend;  // RMW acks one cycle later
        end
    end

    a_stb_in_cyc: assert property (@(posedge cpu_clock_i) disable iff (!rst_n_i)
        wb_stb_i |-> wb_cyc_i);

endmodule

`default_nettype wire

//--- hw/dcache_subsystem.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_settings.svh"

module dcache_subsystem (
    input  wire logic                  cpu_clock_i,
    input  wire logic                  rst_n_i,
    input  wire dcache_pkg::cpu_addr_u cpu_addr_i,
    input  wire logic [31:0]           cpu_data_i,
    input  wire dcache_pkg::mem_size_e cpu_mem_ctrl_i,
    input  wire logic                  cpu_write_i,
    input  wire logic                  cpu_valid_i,
    output logic [31:0]                cpu_data_o,
    output logic                       cpu_en_o
);
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    logic [`DCACHE_AW-1:0] wb_adr;
    logic [31:0]           wb_dat_w;  // Cache to SRAM
    logic [3:0]            wb_sel;
    logic                  wb_stall;
    logic                  wb_ack;
    logic [31:0]           wb_dat_r;  // SRAM to cache
    wire logic             wb_err = 1'b0;  // SRAM has no error output

    direct_mapped_cache_wb dcache_i (
        .cpu_clock_i    (cpu_clock_i),
        .rst_n_i        (rst_n_i),
        .cpu_addr_i     (cpu_addr_i),
        .cpu_data_i     (cpu_data_i),
        .cpu_mem_ctrl_i (cpu_mem_ctrl_i),
        .cpu_write_i    (cpu_write_i),
        .cpu_valid_i    (cpu_valid_i),
        .cpu_data_o     (cpu_data_o),
        .cpu_en_o       (cpu_en_o),
        .wb_stall_i     (wb_stall),
        .wb_ack_i       (wb_ack),
        .wb_err_i       (wb_err),
        .wb_dat_i       (wb_dat_r),
        .wb_cyc_o       (wb_cyc),
        .wb_stb_o       (wb_stb),
        .wb_we_o        (wb_we),
        .wb_adr_o       (wb_adr),
        .wb_dat_o       (wb_dat_w),
        .wb_sel_o       (wb_sel)
    );

    wb_sram sram_i (
        .cpu_clock_i (cpu_clock_i),
        .rst_n_i     (rst_n_i),
        .wb_cyc_i    (wb_cyc),
        .wb_stb_i    (wb_stb),
        .wb_we_i     (wb_we),
        .wb_adr_i    (wb_adr),
        .wb_dat_i    (wb_dat_w),
        .wb_sel_i    (wb_sel),
        .wb_stall_o  (wb_stall),
        .wb_ack_o    (wb_ack),
        .wb_dat_o    (wb_dat_r)
    );

endmodule

`default_nettype wire

//--- tests/dcache_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_settings.svh"

module dcache_tb;
    import dcache_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 8;
    localparam int RANDOM_OPS   = 2000;
    localparam int DIRECTED_OPS = 40;
    localparam int MISS_BOUND   = 40;  // Cycles for evict, fill and stalls
    localparam int BA_W         = `DCACHE_AW + 2;
    localparam int MEM_BYTES    = 2**BA_W;

    logic        cpu_clock;
    logic        rst_n;
    cpu_addr_u   cpu_addr;
    logic [31:0] cpu_data_w;
    mem_size_e   cpu_mem_ctrl;
    logic        cpu_write;
    logic        cpu_valid;
    logic [31:0] cpu_data_r;
    logic        cpu_en;

    logic [7:0]  mem_model [0:MEM_BYTES-1];  // Byte image of the SRAM
    logic [31:0] rng;
    int          errors;
    int          loads_checked;

    dcache_subsystem dcache_subsystem_i (
        .cpu_clock_i    (cpu_clock),
        .rst_n_i        (rst_n),
        .cpu_addr_i     (cpu_addr),
        .cpu_data_i     (cpu_data_w),
        .cpu_mem_ctrl_i (cpu_mem_ctrl),
        .cpu_write_i    (cpu_write),
        .cpu_valid_i    (cpu_valid),
        .cpu_data_o     (cpu_data_r),
        .cpu_en_o       (cpu_en)
    );

    initial begin
        cpu_clock = 1'b0;
        forever #(CLK_PERIOD/2) cpu_clock = ~cpu_clock;
    end

    initial begin
        #((RESET_CYCLES + 4 + (RANDOM_OPS + DIRECTED_OPS) * MISS_BOUND) * CLK_PERIOD);
        $display("ERROR: a CPU request never completed, cpu_en_o stayed low at %0t", $time);
        $display("Run ended by watchdog, %0d loads checked, %0d errors", loads_checked, errors);
        $display("TESTS FAILED");
        $finish;
    end

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [BA_W-1:0] make_addr(input int tag, input int set_idx,
                                                  input int word, input int off);
        cpu_addr_u a;
        a.field.tag      = TAG_W'(tag);
        a.field.set_idx  = SET_W'(set_idx);
        a.field.word_idx = `DCACHE_LINE_POW2'(word);
        a.field.byte_off = 2'(off);
        return a.flat;
    endfunction

    // RV32 load semantics applied to the byte model
    function automatic logic [31:0] expected_load(input logic [BA_W-1:0] addr,
                                                  input mem_size_e size);
        logic [7:0]  b0;
        logic [15:0] h0;
        b0 = mem_model[addr];
        case (size)
            MEM_BYTE:   return {{24{b0[7]}}, b0};
            MEM_BYTE_U: return {24'b0, b0};
            MEM_HALF: begin
                h0 = {mem_model[addr + 1], b0};
                return {{16{h0[15]}}, h0};
            end
            MEM_HALF_U: return {16'b0, mem_model[addr + 1], b0};
            default:    return {mem_model[addr + 3], mem_model[addr + 2], mem_model[addr + 1], b0};
        endcase
    endfunction

    task automatic store_model(input logic [BA_W-1:0] addr, input mem_size_e size,
                               input logic [31:0] data);
        int n;
        n = (size == MEM_WORD) ? 4 : ((size == MEM_HALF) ? 2 : 1);
        for (int k = 0; k < n; k++) begin
            mem_model[addr + k] = data[8*k +: 8];
        end
    endtask

    // Called on a falling edge, returns on the falling edge after completion
    task automatic run_request(input logic write, input logic [BA_W-1:0] addr,
                               input mem_size_e size, input logic [31:0] data);
        logic [31:0] expected;
        expected      = expected_load(addr, size);
        cpu_valid     = 1'b1;
        cpu_write     = write;
        cpu_addr.flat = addr;
        cpu_data_w    = data;
        cpu_mem_ctrl  = size;
        #(CLK_PERIOD/2 - 1);  // Just before the rising edge
        while (!cpu_en) begin
            @(negedge cpu_clock);
            #(CLK_PERIOD/2 - 1);
        end
        if (!write) begin
            loads_checked++;
            if (cpu_data_r !== expected) begin
                errors++;
                $display("CHECK FAILED t=%0t addr=%h expected=%h actual=%h",
                         $time, addr, expected, cpu_data_r);
            end
        end else begin
            store_model(addr, size, data);
        end
        @(negedge cpu_clock);
    endtask

    initial begin
        logic [BA_W-1:0] a;
        logic [BA_W-1:0] b;
        logic [31:0]     r;
        mem_size_e       size;
        int              off;
        cpu_valid     = 1'b0;
        cpu_write     = 1'b0;
        cpu_addr      = '0;
        cpu_data_w    = '0;
        cpu_mem_ctrl  = MEM_WORD;
        rst_n         = 1'b0;
        errors        = 0;
        loads_checked = 0;
        rng           = 32'd95116;
        for (int i = 0; i < MEM_BYTES; i++) begin
            mem_model[i] = 8'h00;
        end
        repeat (RESET_CYCLES) @(negedge cpu_clock);
        rst_n = 1'b1;
        @(negedge cpu_clock);
        #(CLK_PERIOD/2 - 1);
        if (cpu_en !== 1'b1) begin
            errors++;
            $display("CHECK FAILED t=%0t cpu_en_o low while idle after reset", $time);
        end
        @(negedge cpu_clock);
        run_request(1'b0, make_addr(5, 11, 2, 0), MEM_WORD, 32'h0);  // Fresh memory reads zero

        // Full word stored past the cache, then every load size
        a = make_addr(6, 5, 1, 0);
        run_request(1'b1, a, MEM_WORD, 32'h8F7E_A5C3);
        for (int k = 0; k < 4; k++) begin
            run_request(1'b0, a + k, MEM_BYTE, 32'h0);
            run_request(1'b0, a + k, MEM_BYTE_U, 32'h0);
        end
        run_request(1'b0, a, MEM_HALF, 32'h0);
        run_request(1'b0, a + 2, MEM_HALF, 32'h0);
        run_request(1'b0, a, MEM_HALF_U, 32'h0);
        run_request(1'b0, a + 2, MEM_HALF_U, 32'h0);
        run_request(1'b0, a, MEM_WORD, 32'h0);

        // Store hits on the now cached line
        run_request(1'b1, a + 1, MEM_BYTE, 32'h0000_0011);
        run_request(1'b1, a + 2, MEM_HALF, 32'h0000_2233);
        run_request(1'b0, a, MEM_WORD, 32'h0);

        // Partial store miss goes through the SRAM read-modify-write
        b = make_addr(7, 6, 3, 2);
        run_request(1'b1, b, MEM_HALF, 32'h0000_BEEF);
        run_request(1'b0, b - 2, MEM_WORD, 32'h0);
        run_request(1'b0, b + 1, MEM_BYTE, 32'h0);

        // Dirty line in set 9 pushed out by two other tags
        run_request(1'b0, make_addr(1, 9, 0, 0), MEM_WORD, 32'h0);
        for (int w = 0; w < 4; w++) begin
            run_request(1'b1, make_addr(1, 9, w, 0), MEM_WORD, 32'hC0DE_0000 + w);
        end
        run_request(1'b0, make_addr(2, 9, 1, 0), MEM_WORD, 32'h0);
        run_request(1'b0, make_addr(3, 9, 2, 0), MEM_WORD, 32'h0);
        for (int w = 0; w < 4; w++) begin
            run_request(1'b0, make_addr(1, 9, w, 0), MEM_WORD, 32'h0);
        end

        for (int n = 0; n < RANDOM_OPS; n++) begin
            rng = next_random(rng);
            r   = rng;
            if (r[31]) begin  // Store
                size = (r[9:8] == 2'd0) ? MEM_WORD : ((r[9:8] == 2'd1) ? MEM_HALF : MEM_BYTE);
            end else begin
                case (r[10:8] % 5)
                    0: size = MEM_BYTE;
                    1: size = MEM_HALF;
                    2: size = MEM_WORD;
                    3: size = MEM_BYTE_U;
                    default: size = MEM_HALF_U;
                endcase
            end
            off = (size == MEM_WORD) ? 0 : ((size == MEM_HALF || size == MEM_HALF_U) ?
                  int'(r[6]) * 2 : int'(r[6:5]));
            a   = make_addr(int'(r[1:0]), r[2] ? 17 : 3, int'(r[4:3]), off);
            rng = next_random(rng);
            run_request(r[31], a, size, rng);
        end
        cpu_valid = 1'b0;

        $display("Run complete, %0d loads checked, %0d errors", loads_checked, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+common
common/dcache_pkg.sv
dcache/load_format.sv
dcache/store_format.sv
dcache/direct_mapped_cache_wb.sv
hw/wb_sram.sv
hw/dcache_subsystem.sv
tests/dcache_tb.sv
